// ==== hw/dac_consts.svh ====
`ifndef DAC_CONSTS_SVH
`define DAC_CONSTS_SVH

// sample geometry
`define DAC_SAMPLE_W   16
`define DAC_BATCH_SIZE 4

// command field widths
`define DAC_BS_W    8
`define DAC_SCALE_W 4

// galois taps for the per-lane lfsr (x^16 + x^14 + x^13 + x^11 + 1)
`define DAC_LFSR_TAPS 16'hB400

`define DAC_LINK_LAT 2 // cycles from accept to delivery

`endif

// ==== hw/dac_pkg.sv ====
`include "dac_consts.svh"

package dac_pkg;

	typedef enum logic [1:0] {
		OP_CFG,
		OP_PWL,
		OP_TRIG,
		OP_RAND
	} dac_op_e;

	typedef logic [`DAC_BATCH_SIZE-1:0][`DAC_SAMPLE_W-1:0] sample_batch_t;

	typedef struct packed {
		dac_op_e                 op;
		logic                    halt;       // stops the generator, op ignored
		sample_batch_t           seed;       // one seed per lane
		logic [`DAC_SCALE_W-1:0] scale;
		logic [`DAC_BS_W-1:0]    burst_size;
	} ps_cmd_t;

	typedef struct packed {
		logic        pwl_ready;
		logic [15:0] pwl_period; // in samples
	} dac_resp_t;

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ `DAC_LFSR_TAPS;
		return state >> 1;
	endfunction

endpackage

// ==== hw/change_detect.sv ====
module change_detect #(
	parameter type data_t = logic
) (
	input  logic  ps_clk,
	input  logic  ps_rst,
	input  data_t val_i,
	output logic  changed_o
);

	data_t val_q;

	// high for the one cycle where the input differs from last cycle
	assign changed_o = (val_i != val_q);

	always_ff @(posedge ps_clk) begin
		if (ps_rst)
			val_q <= '0;
		else
			val_q <= val_i;
	end

endmodule

// ==== hw/cmd_link.sv ====
`include "dac_consts.svh"

module cmd_link #(
	parameter type payload_t = logic
) (
	input  logic     ps_clk,
	input  logic     ps_rst,
	input  payload_t data_i,
	input  logic     valid_i,
	output payload_t data_o,
	output logic     valid_o,
	output logic     rdy_o,
	output logic     done_o
);

	localparam int CNT_W = $clog2(`DAC_LINK_LAT + 1);

	logic             pend;    // slot holds an undelivered payload
	logic [CNT_W-1:0] lat_cnt;
	logic             accept;

	assign accept  = valid_i && rdy_o;
	assign valid_o = pend && (lat_cnt == '0); // delivery when countdown runs out

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			pend    <= 1'b0;
			lat_cnt <= '0;
			rdy_o   <= 1'b1;
			done_o  <= 1'b0;
		end else begin
			done_o <= valid_o;
			if (accept) begin
				pend    <= 1'b1;
				lat_cnt <= CNT_W'(`DAC_LINK_LAT - 1);
				rdy_o   <= 1'b0;
			end else if (valid_o) begin
				pend  <= 1'b0;
				rdy_o <= 1'b1; // slot freed together with done
			end else if (pend) begin
				lat_cnt <= lat_cnt - 1'b1;
			end
		end
	end

	// single slot, written only when the sender is accepted
	always_ff @(posedge ps_clk) begin
		if (accept)
			data_o <= data_i;
	end

endmodule

// ==== hw/dac_cmd_ctrl.sv ====
`include "dac_consts.svh"

module dac_cmd_ctrl (
	input  logic                    ps_clk,
	input  logic                    ps_rst,
	input  logic                    run_pwl_i,
	input  logic                    run_trig_i,
	input  logic                    run_rand_i,
	input  dac_pkg::sample_batch_t  seed_i,
	input  logic [`DAC_SCALE_W-1:0] scale_i,
	input  logic [`DAC_BS_W-1:0]    burst_size_i,
	input  logic                    halt_i,
	input  logic                    cmd_rdy_i,
	input  logic                    cmd_done_i,
	input  dac_pkg::dac_resp_t      resp_i,
	input  logic                    resp_valid_i,
	input  logic                    resp_rdy_i,
	output dac_pkg::ps_cmd_t        cmd_o,
	output logic                    cmd_valid_o,
	output logic                    pwl_ready_o,
	output logic [15:0]             pwl_period_o,
	output logic                    cmd_idle_o
);

	import dac_pkg::*;

	typedef enum logic [1:0] {IDLE, SEND, PWL_WAIT, HALT} state_e;

	state_e        state;
	dac_op_e       op_q;
	logic          halt_q;
	sample_batch_t seed_q;
	logic          scale_chg_w;
	logic          bs_chg_w;
	logic          scale_pend;
	logic          bs_pend;

	change_detect #(.data_t(logic [`DAC_SCALE_W-1:0])) scale_chg (
		.ps_clk    (ps_clk),
		.ps_rst    (ps_rst),
		.val_i     (scale_i),
		.changed_o (scale_chg_w)
	);

	change_detect #(.data_t(logic [`DAC_BS_W-1:0])) bs_chg (
		.ps_clk    (ps_clk),
		.ps_rst    (ps_rst),
		.val_i     (burst_size_i),
		.changed_o (bs_chg_w)
	);

	// scale and burst size always go out with their live values
	assign cmd_o = '{op: op_q, halt: halt_q, seed: seed_q,
		scale: scale_i, burst_size: burst_size_i};

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			state        <= IDLE;
			op_q         <= OP_CFG;
			halt_q       <= 1'b0;
			seed_q       <= '0;
			cmd_valid_o  <= 1'b0;
			cmd_idle_o   <= 1'b1;
			scale_pend   <= 1'b0;
			bs_pend      <= 1'b0;
			pwl_ready_o  <= 1'b0;
			pwl_period_o <= '0;
		end else begin
			if (resp_valid_i) begin
				pwl_ready_o  <= resp_i.pwl_ready;
				pwl_period_o <= resp_i.pwl_period;
			end
			if (scale_chg_w)
				scale_pend <= 1'b1;
			if (bs_chg_w)
				bs_pend <= 1'b1;

			if (halt_i) begin
				cmd_valid_o <= 1'b0;
				cmd_idle_o  <= 1'b0;
				state       <= HALT;
			end else begin
				case (state)
					IDLE: begin
						if (cmd_idle_o) begin // strobes only count while idle
							if (run_pwl_i) begin
								op_q       <= OP_PWL;
								cmd_idle_o <= 1'b0;
								if (!pwl_ready_o || !resp_rdy_i)
									state <= PWL_WAIT;
								else
									cmd_valid_o <= 1'b1;
							end else if (run_rand_i) begin
								op_q        <= OP_RAND;
								seed_q      <= seed_i;
								cmd_valid_o <= 1'b1;
								cmd_idle_o  <= 1'b0;
							end else if (run_trig_i) begin
								op_q        <= OP_TRIG;
								cmd_valid_o <= 1'b1;
								cmd_idle_o  <= 1'b0;
							end else if (scale_pend) begin
								op_q        <= OP_CFG;
								scale_pend  <= 1'b0;
								cmd_valid_o <= 1'b1;
								cmd_idle_o  <= 1'b0;
							end else if (bs_pend) begin
								op_q        <= OP_CFG;
								bs_pend     <= 1'b0;
								cmd_valid_o <= 1'b1;
								cmd_idle_o  <= 1'b0;
							end
						end
						if (cmd_valid_o && cmd_rdy_i) begin
							cmd_valid_o <= 1'b0;
							halt_q      <= 1'b0; // one halt per request
							state       <= SEND;
						end
					end
					SEND: begin
						if (cmd_done_i) begin
							state      <= IDLE;
							cmd_idle_o <= 1'b1;
						end
					end
					PWL_WAIT: begin
						// generator must be stopped and able to answer
						if (pwl_ready_o && resp_rdy_i) begin
							cmd_valid_o <= 1'b1;
							state       <= IDLE;
						end
					end
					HALT: begin
						op_q        <= OP_CFG;
						halt_q      <= 1'b1;
						cmd_valid_o <= 1'b1;
						state       <= IDLE;
					end
				endcase
			end
		end
	end

endmodule

// ==== hw/sample_gen.sv ====
`include "dac_consts.svh"

module sample_gen (
	input  logic                    ps_clk,
	input  logic                    ps_rst,
	input  dac_pkg::ps_cmd_t        cmd_i,
	input  logic                    cmd_valid_i,
	input  logic                    dac_rdy_i,
	input  logic                    resp_rdy_i,
	output dac_pkg::dac_resp_t      resp_o,
	output logic                    resp_valid_o,
	output dac_pkg::sample_batch_t  batch_o,
	output logic                    batch_valid_o,
	output logic [`DAC_SCALE_W-1:0] scale_o
);

	import dac_pkg::*;

	localparam int SAMPLE_W = `DAC_SAMPLE_W;

	dac_op_e              mode;
	logic                 running;
	logic                 resp_pend;  // response waiting for the link
	logic [`DAC_BS_W-1:0] bs_q;
	logic [`DAC_BS_W-1:0] k_q;        // batch index within the ramp
	sample_batch_t        lfsr_q;
	logic                 last_batch;
	logic                 step;
	logic                 start;

	assign step       = running && dac_rdy_i;
	assign start      = cmd_valid_i && !cmd_i.halt && (cmd_i.op != OP_CFG);
	assign last_batch = (k_q >= bs_q - 1'b1);

	assign resp_valid_o = resp_pend && resp_rdy_i;
	assign resp_o = '{pwl_ready: !running, pwl_period: 16'(bs_q * `DAC_BATCH_SIZE)};

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			mode          <= OP_CFG;
			running       <= 1'b0;
			resp_pend     <= 1'b0;
			bs_q          <= '0;
			scale_o       <= '0;
			batch_valid_o <= 1'b0;
		end else begin
			batch_valid_o <= step;
			if (resp_valid_o)
				resp_pend <= 1'b0;
			if (step && (mode == OP_TRIG) && last_batch) begin
				running   <= 1'b0;
				resp_pend <= 1'b1; // end of burst is reported too
			end
			if (cmd_valid_i) begin
				scale_o   <= cmd_i.scale;
				bs_q      <= cmd_i.burst_size;
				resp_pend <= 1'b1;
				if (cmd_i.halt) begin
					running <= 1'b0;
				end else if (cmd_i.op != OP_CFG) begin
					mode    <= cmd_i.op;
					running <= (cmd_i.op == OP_RAND) || (cmd_i.burst_size != '0);
				end
			end
		end
	end

	always_ff @(posedge ps_clk) begin
		if (step) begin
			for (int i = 0; i < `DAC_BATCH_SIZE; i++) begin
				if (mode == OP_RAND) begin
					batch_o[i] <= lfsr_q[i];
					lfsr_q[i]  <= lfsr_step(lfsr_q[i]);
				end else begin
					batch_o[i] <= SAMPLE_W'(k_q * `DAC_BATCH_SIZE + i);
				end
			end
			if (mode != OP_RAND)
				k_q <= last_batch ? '0 : k_q + 1'b1;
		end
		// a new mode restarts the ramp and reseeds the lanes
		if (start) begin
			k_q <= '0;
			for (int i = 0; i < `DAC_BATCH_SIZE; i++)
				lfsr_q[i] <= (cmd_i.seed[i] == '0) ? SAMPLE_W'(1) : cmd_i.seed[i];
		end
	end

endmodule

// ==== hw/batch_scaler.sv ====
`include "dac_consts.svh"

module batch_scaler (
	input  logic                    ps_clk,
	input  logic                    ps_rst,
	input  dac_pkg::sample_batch_t  batch_i,
	input  logic                    valid_i,
	input  logic [`DAC_SCALE_W-1:0] scale_i,
	output dac_pkg::sample_batch_t  batch_o,
	output logic                    valid_o
);

	always_ff @(posedge ps_clk) begin
		if (ps_rst)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	// logical shift, every lane by the same amount
	always_ff @(posedge ps_clk) begin
		for (int i = 0; i < `DAC_BATCH_SIZE; i++)
			batch_o[i] <= batch_i[i] >> scale_i;
	end

endmodule

// ==== hw/dac_channel_top.sv ====
`include "dac_consts.svh"

module dac_channel_top (
	input  logic                    ps_clk,
	input  logic                    ps_rst,
	input  logic                    run_pwl_i,
	input  logic                    run_trig_i,
	input  logic                    run_rand_i,
	input  dac_pkg::sample_batch_t  seed_i,
	input  logic [`DAC_SCALE_W-1:0] scale_i,
	input  logic [`DAC_BS_W-1:0]    burst_size_i,
	input  logic                    halt_i,
	input  logic                    dac_rdy_i,
	output dac_pkg::sample_batch_t  batch_o,
	output logic                    batch_valid_o,
	output logic [15:0]             pwl_period_o,
	output logic                    pwl_ready_o,
	output logic                    save_pwl_period_o,
	output logic                    cmd_idle_o
);

	import dac_pkg::*;

	ps_cmd_t                 cmd_in;
	ps_cmd_t                 cmd_out;
	logic                    cmd_in_valid;
	logic                    cmd_out_valid;
	logic                    cmd_rdy;
	logic                    cmd_done;
	dac_resp_t               resp_in;
	dac_resp_t               resp_out;
	logic                    resp_in_valid;
	logic                    resp_out_valid;
	logic                    resp_rdy;
	sample_batch_t           gen_batch;
	logic                    gen_batch_valid;
	logic [`DAC_SCALE_W-1:0] gen_scale;

	dac_cmd_ctrl ctrl (
		.ps_clk (ps_clk), .ps_rst (ps_rst),
		.run_pwl_i (run_pwl_i), .run_trig_i (run_trig_i), .run_rand_i (run_rand_i),
		.seed_i (seed_i), .scale_i (scale_i), .burst_size_i (burst_size_i),
		.halt_i (halt_i), .cmd_rdy_i (cmd_rdy), .cmd_done_i (cmd_done),
		.resp_i (resp_out), .resp_valid_i (resp_out_valid), .resp_rdy_i (resp_rdy),
		.cmd_o (cmd_in), .cmd_valid_o (cmd_in_valid),
		.pwl_ready_o (pwl_ready_o), .pwl_period_o (pwl_period_o),
		.cmd_idle_o (cmd_idle_o)
	);

	// processor to generator
	cmd_link #(.payload_t(ps_cmd_t)) cmd_fwd (
		.ps_clk (ps_clk), .ps_rst (ps_rst),
		.data_i (cmd_in), .valid_i (cmd_in_valid),
		.data_o (cmd_out), .valid_o (cmd_out_valid),
		.rdy_o (cmd_rdy), .done_o (cmd_done)
	);

	// status back to the processor side
	cmd_link #(.payload_t(dac_resp_t)) resp_back (
		.ps_clk (ps_clk), .ps_rst (ps_rst),
		.data_i (resp_in), .valid_i (resp_in_valid),
		.data_o (resp_out), .valid_o (resp_out_valid),
		.rdy_o (resp_rdy), .done_o ()
	);

	sample_gen gen (
		.ps_clk (ps_clk), .ps_rst (ps_rst),
		.cmd_i (cmd_out), .cmd_valid_i (cmd_out_valid),
		.dac_rdy_i (dac_rdy_i), .resp_rdy_i (resp_rdy),
		.resp_o (resp_in), .resp_valid_o (resp_in_valid),
		.batch_o (gen_batch), .batch_valid_o (gen_batch_valid),
		.scale_o (gen_scale)
	);

	batch_scaler scaler (
		.ps_clk (ps_clk), .ps_rst (ps_rst),
		.batch_i (gen_batch), .valid_i (gen_batch_valid), .scale_i (gen_scale),
		.batch_o (batch_o), .valid_o (batch_valid_o)
	);

	change_detect #(.data_t(logic [15:0])) period_chg (
		.ps_clk (ps_clk), .ps_rst (ps_rst),
		.val_i (pwl_period_o), .changed_o (save_pwl_period_o)
	);

endmodule

// ==== sim/dac_tb.sv ====
`include "dac_consts.svh"

module dac_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import dac_pkg::*;

	localparam int M_NONE = 0;
	localparam int M_RAND = 1;
	localparam int M_TRIG = 2;
	localparam int M_PWL  = 3;
	localparam int STB_PWL  = 0;
	localparam int STB_RAND = 1;
	localparam int STB_TRIG = 2;
	localparam int STB_HALT = 3;
	localparam int RAND_BATCHES = 40;
	localparam int MAX_BS = 16;
	localparam int N_PHASES = 8; // cfg, rand, trig, bs cfg, scale cfg, pwl, pwl again, margin
	// a phase needs at most about 3 bursts at half rate plus settling
	localparam int TIMEOUT_CYCLES = N_PHASES * (4 * (3 * MAX_BS + 1) + 60) + 20;

	logic                    ps_clk;
	logic                    ps_rst;
	logic                    run_pwl_i;
	logic                    run_trig_i;
	logic                    run_rand_i;
	sample_batch_t           seed_i;
	logic [`DAC_SCALE_W-1:0] scale_i;
	logic [`DAC_BS_W-1:0]    burst_size_i;
	logic                    halt_i;
	logic                    dac_rdy_i;
	sample_batch_t           batch_o;
	logic                    batch_valid_o;
	logic [15:0]             pwl_period_o;
	logic                    pwl_ready_o;
	logic                    save_pwl_period_o;
	logic                    cmd_idle_o;

	logic [15:0] rng_state;
	int          value_errs;
	int          other_errs;
	int          batch_cnt;
	int          save_cnt;
	int          cycle_cnt;

	// reference model of the generator output
	int          m_mode;
	int          m_k;
	int          m_bs;
	logic [3:0]  m_scale;
	logic [15:0] m_lanes [`DAC_BATCH_SIZE];

	dac_channel_top dut (
		.ps_clk (ps_clk), .ps_rst (ps_rst),
		.run_pwl_i (run_pwl_i), .run_trig_i (run_trig_i), .run_rand_i (run_rand_i),
		.seed_i (seed_i), .scale_i (scale_i), .burst_size_i (burst_size_i),
		.halt_i (halt_i), .dac_rdy_i (dac_rdy_i),
		.batch_o (batch_o), .batch_valid_o (batch_valid_o),
		.pwl_period_o (pwl_period_o), .pwl_ready_o (pwl_ready_o),
		.save_pwl_period_o (save_pwl_period_o), .cmd_idle_o (cmd_idle_o)
	);

	always #10 ps_clk = ~ps_clk;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			rng_state = rng_state[0] ? ((rng_state >> 1) ^ 16'hD008) : (rng_state >> 1);
			r = {r[30:0], rng_state[0]};
		end
		return r;
	endfunction

	function automatic logic [15:0] lane_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ `DAC_LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic expect_eq(input string what, input int got, input int exp);
		assert (got == exp) else begin
			value_errs++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic start_model(input int mode, input int bs, input int scale);
		m_mode = mode;
		m_k = 0;
		m_bs = bs;
		m_scale = 4'(scale);
		batch_cnt = 0;
	endtask

	task automatic issue_strobe(input int which);
		do
			@(negedge ps_clk);
		while (!cmd_idle_o);
		@(posedge ps_clk);
		case (which)
			STB_PWL:  run_pwl_i  <= 1'b1;
			STB_RAND: run_rand_i <= 1'b1;
			STB_TRIG: run_trig_i <= 1'b1;
			default:  halt_i     <= 1'b1;
		endcase
		@(posedge ps_clk);
		run_pwl_i  <= 1'b0;
		run_rand_i <= 1'b0;
		run_trig_i <= 1'b0;
		halt_i     <= 1'b0;
	endtask

	// controller idle for a stretch, so commands and responses have landed
	task automatic settle();
		int quiet;
		quiet = 0;
		while (quiet < 10) begin
			@(negedge ps_clk);
			if (cmd_idle_o)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic wait_batches(input int n);
		while (batch_cnt < n)
			@(posedge ps_clk);
	endtask

	task automatic halt_and_check_quiet();
		issue_strobe(STB_HALT);
		settle();
		@(posedge ps_clk);
		m_mode = M_NONE; // any batch from here on is an error
		repeat (20) @(posedge ps_clk);
		@(negedge ps_clk);
		expect_eq("pwl_ready_o after halt", int'(pwl_ready_o), 1);
	endtask

	always @(posedge ps_clk) begin
		if (!ps_rst)
			dac_rdy_i <= (rand_bits(1) != 0);
	end

	always @(negedge ps_clk) begin
		sample_batch_t exp_b;
		if (save_pwl_period_o === 1'b1)
			save_cnt++;
		if (!ps_rst && batch_valid_o === 1'b1) begin
			assert (m_mode != M_NONE) else begin
				other_errs++;
				$display("batch output at %0t while the generator should be stopped", $time);
			end
			if (m_mode != M_NONE) begin
				for (int i = 0; i < `DAC_BATCH_SIZE; i++) begin
					if (m_mode == M_RAND) begin
						exp_b[i] = m_lanes[i] >> m_scale;
						m_lanes[i] = lane_next(m_lanes[i]);
					end else begin
						exp_b[i] = 16'(m_k * `DAC_BATCH_SIZE + i) >> m_scale;
					end
				end
				assert (batch_o == exp_b) else begin
					value_errs++;
					$display("FAILED at %0t: batch %0d is %h, expected %h",
						$time, batch_cnt, batch_o, exp_b);
				end
				if (m_mode != M_RAND) begin
					m_k++;
					if (m_k == m_bs) begin
						m_k = 0;
						if (m_mode == M_TRIG)
							m_mode = M_NONE; // burst over
					end
				end
			end
			batch_cnt++; // stray batches count too
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge ps_clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("errors: %0d wrong values, %0d other", value_errs, other_errs + 1);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		sample_batch_t seed;
		int sc;
		int tbs;
		int nbs;
		int nsc;
		int save_base;

		ps_clk = 1'b0;
		ps_rst = 1'b1;
		run_pwl_i = 1'b0;
		run_trig_i = 1'b0;
		run_rand_i = 1'b0;
		seed_i = '0;
		scale_i = '0;
		burst_size_i = '0;
		halt_i = 1'b0;
		dac_rdy_i = 1'b0;
		rng_state = 16'd57;
		value_errs = 0;
		other_errs = 0;
		save_cnt = 0;
		start_model(M_NONE, 0, 0);
		repeat (10) @(posedge ps_clk);
		ps_rst <= 1'b0;

		repeat (5) begin
			@(negedge ps_clk);
			expect_eq("cmd_idle_o after reset", int'(cmd_idle_o), 1);
			expect_eq("batch_valid_o after reset", int'(batch_valid_o), 0);
			expect_eq("pwl_ready_o after reset", int'(pwl_ready_o), 0);
		end

		// first scale and burst size go out as cfg commands
		@(negedge ps_clk);
		sc = rand_bits(2);
		tbs = rand_bits(4) + 1;
		@(posedge ps_clk);
		scale_i <= 4'(sc);
		burst_size_i <= 8'(tbs);
		settle();
		expect_eq("pwl_ready_o after cfg", int'(pwl_ready_o), 1);
		expect_eq("pwl_period_o after cfg", int'(pwl_period_o), tbs * `DAC_BATCH_SIZE);

		// random mode
		@(negedge ps_clk);
		for (int i = 0; i < `DAC_BATCH_SIZE; i++)
			seed[i] = 16'(rand_bits(16));
		@(posedge ps_clk);
		seed_i <= seed;
		start_model(M_RAND, 0, sc);
		for (int i = 0; i < `DAC_BATCH_SIZE; i++)
			m_lanes[i] = (seed[i] == '0) ? 16'd1 : seed[i];
		issue_strobe(STB_RAND);
		wait_batches(RAND_BATCHES);
		halt_and_check_quiet();

		// triggered burst
		@(negedge ps_clk);
		tbs = rand_bits(4) + 1;
		@(posedge ps_clk);
		burst_size_i <= 8'(tbs);
		settle();
		@(posedge ps_clk);
		start_model(M_TRIG, tbs, sc);
		issue_strobe(STB_TRIG);
		wait_batches(tbs);
		settle();
		expect_eq("burst batch count", batch_cnt, tbs);
		expect_eq("pwl_ready_o after burst", int'(pwl_ready_o), 1);
		expect_eq("pwl_period_o after burst", int'(pwl_period_o), tbs * `DAC_BATCH_SIZE);

		// burst size alone, then scale alone
		@(negedge ps_clk);
		nbs = rand_bits(3) + 2;
		if (nbs == tbs)
			nbs++;
		@(posedge ps_clk);
		save_base = save_cnt;
		burst_size_i <= 8'(nbs);
		settle();
		expect_eq("save_pwl_period_o pulses", save_cnt - save_base, 1);
		expect_eq("pwl_period_o after bs cfg", int'(pwl_period_o), nbs * `DAC_BATCH_SIZE);
		@(negedge ps_clk);
		nsc = (sc + 1 + rand_bits(1)) % 4;
		@(posedge ps_clk);
		scale_i <= 4'(nsc);
		settle();

		// pwl wraps, halt stops it, a new run starts over at batch 0
		@(posedge ps_clk);
		start_model(M_PWL, nbs, nsc);
		issue_strobe(STB_PWL);
		wait_batches(3 * nbs + 1);
		halt_and_check_quiet();
		@(posedge ps_clk);
		start_model(M_PWL, nbs, nsc);
		issue_strobe(STB_PWL);
		wait_batches(nbs + 2);
		halt_and_check_quiet();

		$display("errors: %0d wrong values, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+hw
hw/dac_pkg.sv
hw/change_detect.sv
hw/cmd_link.sv
hw/dac_cmd_ctrl.sv
hw/sample_gen.sv
hw/batch_scaler.sv
hw/dac_channel_top.sv
sim/dac_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dac channel testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module dac_tb --Mdir obj_dir -o dac_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/dac_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation passed"
exit 0
